// File: logic/rob_alloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_alloc (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              disp_valid,
    input  rob_pkg::rob_idx_t head,
    input  rob_pkg::rob_cnt_t commit_cnt,
    input  rob_pkg::flush_t   flush,
    output logic              disp_ready,
    output logic              disp_accept,
    output rob_pkg::rob_idx_t tail,
    output rob_pkg::rob_cnt_t count
);

    import rob_pkg::*;

    rob_idx_t flush_tail;
    rob_idx_t flush_span;
    rob_cnt_t flush_count;
    rob_cnt_t disp_add;

    // room for a whole group, and no recovery going on
    assign disp_ready  = !flush.valid && (count <= rob_cnt_t'(`ROB_DEPTH - `DISPATCH_W));
    assign disp_accept = disp_valid && disp_ready;

    // restart right behind the mispredicted branch
    assign flush_tail = flush.brnc_idx + 1'b1;
    assign flush_span = flush_tail - head;

    // the branch itself is still in the buffer, so a zero span means full
    assign flush_count = (flush_span == '0) ? rob_cnt_t'(`ROB_DEPTH) : {1'b0, flush_span};

    assign disp_add = disp_accept ? rob_cnt_t'(`DISPATCH_W) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail  <= '0;
            count <= '0;
        end else if (flush.valid) begin
            tail  <= flush_tail;
            // entries retired this cycle are older than the branch
            count <= flush_count - commit_cnt;
        end else begin
            if (disp_accept) begin
                tail <= tail + rob_idx_t'(`DISPATCH_W);
            end
            count <= count + disp_add - commit_cnt;
        end
    end

endmodule

`default_nettype wire

// File: logic/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// number of reorder buffer entries
`define ROB_DEPTH 16

// entry index width, log2 of ROB_DEPTH
`define ROB_IDX_W 4

// instruction slots per dispatch group
`define DISPATCH_W 2

// retirements per cycle at most
`define COMMIT_W 2

// physical register number width
`define PREG_W 6

// recovery pc width
`define PC_W 16

`endif

// File: logic/rob_entries.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_entries (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    disp_accept,
    input  rob_pkg::rob_idx_t       tail,
    input  rob_pkg::dispatch_group_t disp_group,
    input  rob_pkg::completion_t    cmpl0,
    input  rob_pkg::completion_t    cmpl1,
    input  rob_pkg::brnc_result_t   brnc_res,
    input  rob_pkg::rob_idx_t       head,
    input  rob_pkg::rob_cnt_t       commit_cnt,
    output rob_pkg::flush_t         flush,
    output logic [`ROB_DEPTH-1:0]   vld,
    output logic [`ROB_DEPTH-1:0]   done,
    output logic [`ROB_DEPTH-1:0]   reg_wrt,
    output rob_pkg::preg_t          free_preg [`ROB_DEPTH]
);

    import rob_pkg::*;

    logic [`ROB_DEPTH-1:0] is_brnc;
    logic [`ROB_DEPTH-1:0] brnc_pred;
    logic [`PC_W-1:0]      rcvr_pc_mem [`ROB_DEPTH];

    logic [`ROB_DEPTH-1:0] wr_en;
    dispatch_slot_t        wr_data [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] kill;
    logic [`ROB_DEPTH-1:0] mark_done;
    rob_idx_t              age [`ROB_DEPTH];
    rob_idx_t              brnc_age;
    logic                  res_hit;

    // result lands on a live branch entry
    assign res_hit = brnc_res.valid && vld[brnc_res.idx] && is_brnc[brnc_res.idx];

    assign flush.valid    = res_hit && (brnc_pred[brnc_res.idx] != brnc_res.taken);
    assign flush.brnc_idx = brnc_res.idx;
    assign flush.rcvr_pc  = rcvr_pc_mem[brnc_res.idx];

    // position relative to the head, 0 is the oldest
    assign brnc_age = brnc_res.idx - head;

    for (genvar e = 0; e < `ROB_DEPTH; e++) begin : g_age
        assign age[e] = rob_idx_t'(e) - head;
    end

    always_comb begin
        for (int e = 0; e < `ROB_DEPTH; e++) begin
            wr_en[e]   = 1'b0;
            wr_data[e] = '0;
            for (int s = 0; s < `DISPATCH_W; s++) begin
                if (disp_accept && (rob_idx_t'(tail + s) == rob_idx_t'(e))) begin
                    wr_en[e]   = 1'b1;
                    wr_data[e] = disp_group[s];
                end
            end
            // retired at the head, or wrong-path behind the branch
            kill[e] = ({1'b0, age[e]} < commit_cnt) ||
                      (flush.valid && (age[e] > brnc_age));
            mark_done[e] = (cmpl0.valid && (cmpl0.idx == rob_idx_t'(e))) ||
                           (cmpl1.valid && (cmpl1.idx == rob_idx_t'(e))) ||
                           (res_hit && (brnc_res.idx == rob_idx_t'(e)));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld  <= '0;
            done <= '0;
        end else begin
            for (int e = 0; e < `ROB_DEPTH; e++) begin
                if (wr_en[e]) begin
                    vld[e]  <= 1'b1;
                    // a nop slot needs no completion
                    done[e] <= !wr_data[e].valid;
                end else begin
                    if (kill[e]) begin
                        vld[e] <= 1'b0;
                    end
                    if (mark_done[e]) begin
                        done[e] <= 1'b1;
                    end
                end
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        for (int e = 0; e < `ROB_DEPTH; e++) begin
            if (wr_en[e]) begin
                reg_wrt[e]     <= wr_data[e].valid && wr_data[e].reg_wrt;
                is_brnc[e]     <= wr_data[e].valid && wr_data[e].is_brnc;
                brnc_pred[e]   <= wr_data[e].brnc_pred;
                free_preg[e]   <= wr_data[e].free_preg;
                rcvr_pc_mem[e] <= wr_data[e].rcvr_pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rob_pkg.sv
`default_nettype none

`include "rob_cfg.svh"

package rob_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
    // one extra bit so a full buffer is distinct from an empty one
    typedef logic [`ROB_IDX_W:0]   rob_cnt_t;
    typedef logic [`PREG_W-1:0]    preg_t;

    // one slot of a dispatch group
    typedef struct packed {
        logic                valid;
        logic                reg_wrt;
        logic                is_brnc;
        logic                brnc_pred;
        preg_t               free_preg;
        logic [`PC_W-1:0]    rcvr_pc;
    } dispatch_slot_t;

    // slot 0 is the oldest instruction of the group
    typedef dispatch_slot_t [`DISPATCH_W-1:0] dispatch_group_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
    } completion_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
        logic     taken;
    } brnc_result_t;

    typedef struct packed {
        logic             valid;
        rob_idx_t         brnc_idx;
        logic [`PC_W-1:0] rcvr_pc;
    } flush_t;

    typedef struct packed {
        logic  valid;
        logic  reg_wrt;
        preg_t free_preg;
    } commit_t;

    // lane 0 carries the head entry
    typedef commit_t [`COMMIT_W-1:0] commit_group_t;

endpackage

`default_nettype wire

// File: logic/rob_retire.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_retire (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`ROB_DEPTH-1:0]  vld,
    input  logic [`ROB_DEPTH-1:0]  done,
    input  logic [`ROB_DEPTH-1:0]  reg_wrt,
    input  rob_pkg::preg_t         free_preg [`ROB_DEPTH],
    output rob_pkg::rob_idx_t      head,
    output rob_pkg::rob_cnt_t      commit_cnt,
    output rob_pkg::commit_group_t commit
);

    import rob_pkg::*;

    rob_idx_t lane_idx [`COMMIT_W];

    // entry seen by each lane, wraps with the index width
    for (genvar l = 0; l < `COMMIT_W; l++) begin : g_lane
        assign lane_idx[l] = head + rob_idx_t'(l);
    end

    // in-order window from the head
    always_comb begin
        commit     = '0;
        commit_cnt = '0;
        for (int l = 0; l < `COMMIT_W; l++) begin
            // a lane only fires if every lane below it fired
            if ((commit_cnt == rob_cnt_t'(l)) && vld[lane_idx[l]] && done[lane_idx[l]]) begin
                commit[l].valid     = 1'b1;
                commit[l].reg_wrt   = reg_wrt[lane_idx[l]];
                commit[l].free_preg = free_preg[lane_idx[l]];
                commit_cnt          = commit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else begin
            head <= head + commit_cnt[`ROB_IDX_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/rob_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     disp_valid,
    input  rob_pkg::dispatch_group_t disp_group,
    input  rob_pkg::completion_t     cmpl0,
    input  rob_pkg::completion_t     cmpl1,
    input  rob_pkg::brnc_result_t    brnc_res,
    output logic                     disp_ready,
    output rob_pkg::rob_idx_t        alloc_idx,
    output rob_pkg::commit_group_t   commit,
    output rob_pkg::flush_t          flush
);

    import rob_pkg::*;

    logic                  disp_accept;
    rob_idx_t              head;
    rob_cnt_t              commit_cnt;
    logic [`ROB_DEPTH-1:0] vld;
    logic [`ROB_DEPTH-1:0] done;
    logic [`ROB_DEPTH-1:0] reg_wrt;
    preg_t                 free_preg [`ROB_DEPTH];

    // tail pointer doubles as the dispatch index
    rob_alloc alloc_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .disp_valid  (disp_valid),
        .head        (head),
        .commit_cnt  (commit_cnt),
        .flush       (flush),
        .disp_ready  (disp_ready),
        .disp_accept (disp_accept),
        .tail        (alloc_idx),
        .count       ()
    );

    rob_entries entries_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .disp_accept (disp_accept),
        .tail        (alloc_idx),
        .disp_group  (disp_group),
        .cmpl0       (cmpl0),
        .cmpl1       (cmpl1),
        .brnc_res    (brnc_res),
        .head        (head),
        .commit_cnt  (commit_cnt),
        .flush       (flush),
        .vld         (vld),
        .done        (done),
        .reg_wrt     (reg_wrt),
        .free_preg   (free_preg)
    );

    rob_retire retire_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .vld        (vld),
        .done       (done),
        .reg_wrt    (reg_wrt),
        .free_preg  (free_preg),
        .head       (head),
        .commit_cnt (commit_cnt),
        .commit     (commit)
    );

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_alloc.sv
logic/rob_entries.sv
logic/rob_retire.sv
logic/rob_top.sv
verification/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the reorder buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f project.f -o rob_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rob_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verification/rob_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_tb;

    import rob_pkg::*;

    // live entry of the reference model, oldest at the front
    typedef struct packed {
        rob_idx_t idx;
        logic     reg_wrt;
        preg_t    free_preg;
    } exp_entry_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            disp_valid;
    dispatch_group_t disp_group;
    completion_t     cmpl0 = '0;
    completion_t     cmpl1 = '0;
    brnc_result_t    brnc_res;
    logic            disp_ready;
    rob_idx_t        alloc_idx;
    commit_group_t   commit;
    flush_t          flush;

    integer     seed = 32'h981f95da;
    int         err_cnt = 0;
    int         test_cnt = 0;
    int         test_errs = 0;
    bit         cmpl_en = 1'b0;
    bit         flush_exp = 1'b0;
    preg_t      next_preg = '0;
    rob_idx_t   ref_tail = '0;
    exp_entry_t exp_q[$];
    rob_idx_t   pend_q[$];

    always #4 clk = ~clk;

    rob_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .disp_valid (disp_valid),
        .disp_group (disp_group),
        .cmpl0      (cmpl0),
        .cmpl1      (cmpl1),
        .brnc_res   (brnc_res),
        .disp_ready (disp_ready),
        .alloc_idx  (alloc_idx),
        .commit     (commit),
        .flush      (flush)
    );

    task automatic report_value(input string name, input int got, input int want);
        $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, want);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt == test_errs) ? "ok" : "errors");
        test_errs = err_cnt;
    endtask

    // every slot gets its own free register number
    function automatic dispatch_slot_t make_slot(input logic valid, input logic reg_wrt,
                                                 input logic is_brnc, input logic pred,
                                                 input logic [`PC_W-1:0] pc);
        dispatch_slot_t slot;
        slot.valid     = valid;
        slot.reg_wrt   = reg_wrt;
        slot.is_brnc   = is_brnc;
        slot.brnc_pred = pred;
        slot.free_preg = next_preg;
        slot.rcvr_pc   = pc;
        next_preg      = next_preg + 1'b1;
        return slot;
    endfunction

    function automatic dispatch_group_t plain_group(input logic [`DISPATCH_W-1:0] wr);
        dispatch_group_t grp;
        for (int s = 0; s < `DISPATCH_W; s++) begin
            grp[s] = make_slot(1'b1, wr[s], 1'b0, 1'b0, '0);
        end
        return grp;
    endfunction

    // hold the group until the DUT takes it
    task automatic send_group(input dispatch_group_t grp);
        @(negedge clk);
        disp_valid = 1'b1;
        disp_group = grp;
        do begin
            @(posedge clk);
        end while (!disp_ready);
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic set_completions(input bit on);
        @(posedge clk);
        cmpl_en = on;
    endtask

    task automatic resolve_branch(input rob_idx_t idx, input logic taken,
                                  input logic want_flush, input logic [`PC_W-1:0] pc);
        @(negedge clk);
        brnc_res.valid = 1'b1;
        brnc_res.idx   = idx;
        brnc_res.taken = taken;
        flush_exp      = want_flush;
        @(posedge clk);
        assert (flush.valid == want_flush) else report_value("flush.valid", flush.valid, want_flush);
        if (want_flush) begin
            assert (flush.brnc_idx == idx) else report_value("flush.brnc_idx", flush.brnc_idx, idx);
            assert (flush.rcvr_pc == pc) else report_value("flush.rcvr_pc", flush.rcvr_pc, pc);
        end
        @(negedge clk);
        brnc_res  = '0;
        flush_exp = 1'b0;
        if (want_flush) begin
            assert (alloc_idx == rob_idx_t'(idx + 1'b1))
                else report_value("alloc_idx", alloc_idx, rob_idx_t'(idx + 1'b1));
        end
    endtask

    task automatic drain(input int limit);
        int cyc;
        cyc = 0;
        while (exp_q.size() > 0 && cyc < limit) begin
            @(negedge clk);
            cyc++;
        end
        assert (exp_q.size() == 0) else report_problem("entries did not retire in time");
    endtask

    // random completion order over the entries still waiting
    always @(negedge clk) begin
        int          pick;
        logic [31:0] coin;
        cmpl0 = '0;
        cmpl1 = '0;
        coin  = $random(seed);
        if (cmpl_en && pend_q.size() > 0) begin
            pick = int'($unsigned($random(seed)) % pend_q.size());
            cmpl0.valid = 1'b1;
            cmpl0.idx   = pend_q[pick];
            pend_q.delete(pick);
        end
        if (cmpl_en && pend_q.size() > 0 && coin[0]) begin
            pick = int'($unsigned($random(seed)) % pend_q.size());
            cmpl1.valid = 1'b1;
            cmpl1.idx   = pend_q[pick];
            pend_q.delete(pick);
        end
    end

    // reference model and commit checks
    always @(posedge clk) begin
        exp_entry_t rec;
        int         pos;
        if (rst_n) begin
            if (disp_ready) begin
                assert (alloc_idx == ref_tail) else report_value("alloc_idx", alloc_idx, ref_tail);
            end
            for (int l = 0; l < `COMMIT_W; l++) begin
                if (commit[l].valid) begin
                    assert (exp_q.size() > 0)
                        else report_problem("commit lane valid with no live entry left");
                    if (exp_q.size() > 0) begin
                        rec = exp_q.pop_front();
                        assert (commit[l].reg_wrt == rec.reg_wrt)
                            else report_value($sformatf("commit[%0d].reg_wrt", l),
                                              commit[l].reg_wrt, rec.reg_wrt);
                        assert (!rec.reg_wrt || commit[l].free_preg == rec.free_preg)
                            else report_value($sformatf("commit[%0d].free_preg", l),
                                              commit[l].free_preg, rec.free_preg);
                    end
                end
            end
            if (disp_valid && disp_ready) begin
                for (int s = 0; s < `DISPATCH_W; s++) begin
                    rec.idx       = ref_tail + rob_idx_t'(s);
                    rec.reg_wrt   = disp_group[s].valid && disp_group[s].reg_wrt;
                    rec.free_preg = disp_group[s].free_preg;
                    exp_q.push_back(rec);
                    if (disp_group[s].valid && !disp_group[s].is_brnc) begin
                        pend_q.push_back(rec.idx);
                    end
                end
                ref_tail = ref_tail + rob_idx_t'(`DISPATCH_W);
            end
            if (brnc_res.valid && flush_exp) begin
                pos = -1;
                foreach (exp_q[i]) begin
                    if (exp_q[i].idx == brnc_res.idx) begin
                        pos = i;
                    end
                end
                assert (pos >= 0) else report_problem("flush for a branch that is not live");
                // wrong-path entries leave the model
                while (pos >= 0 && exp_q.size() > pos + 1) begin
                    rec = exp_q.pop_back();
                    for (int k = pend_q.size() - 1; k >= 0; k--) begin
                        if (pend_q[k] == rec.idx) begin
                            pend_q.delete(k);
                        end
                    end
                end
                ref_tail = brnc_res.idx + 1'b1;
            end
        end
    end

    lane_order: assert property (@(posedge clk) disable iff (!rst_n)
                                 !(commit[1].valid && !commit[0].valid))
        else report_problem("commit lane 1 valid above an invalid lane 0");

    flush_blocks_disp: assert property (@(posedge clk) disable iff (!rst_n)
                                        flush.valid |-> !disp_ready)
        else report_problem("dispatch ready during a flush cycle");

    initial begin
        repeat (2000) @(posedge clk);
        $display("watchdog: run did not finish within 2000 cycles");
        $display("tests failed");
        $finish;
    end

    initial begin
        dispatch_group_t grp;
        rob_idx_t        br_idx;
        int              accepted;
        int              cyc;
        logic [31:0]     coin;

        rst_n      = 1'b0;
        disp_valid = 1'b0;
        disp_group = '0;
        brnc_res   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        assert (disp_ready === 1'b1) else report_value("disp_ready", disp_ready, 1);
        assert (alloc_idx == '0) else report_value("alloc_idx", alloc_idx, 0);
        assert (!flush.valid) else report_value("flush.valid", flush.valid, 0);
        for (int l = 0; l < `COMMIT_W; l++) begin
            assert (!commit[l].valid) else report_value("commit.valid", commit[l].valid, 0);
        end
        end_test("reset state");

        set_completions(1'b1);
        repeat (12) begin
            coin = $random(seed);
            send_group(plain_group(coin[`DISPATCH_W-1:0]));
        end
        drain(200);
        end_test("in-order commit");

        // fill without completions until dispatch stalls
        set_completions(1'b0);
        accepted = 0;
        @(negedge clk);
        disp_valid = 1'b1;
        disp_group = plain_group('1);
        while (accepted <= `ROB_DEPTH / `DISPATCH_W) begin
            @(posedge clk);
            if (!disp_ready) begin
                break;
            end
            accepted++;
            @(negedge clk);
            disp_group = plain_group('1);
        end
        assert (accepted == `ROB_DEPTH / `DISPATCH_W)
            else report_value("accepted groups", accepted, `ROB_DEPTH / `DISPATCH_W);
        set_completions(1'b1);
        cyc = 0;
        do begin
            @(posedge clk);
            cyc++;
        end while (!disp_ready && cyc < 100);
        assert (disp_ready) else report_problem("disp_ready stayed low after retirement");
        @(negedge clk);
        disp_valid = 1'b0;
        drain(200);
        end_test("full stall");

        br_idx = ref_tail;
        grp[0] = make_slot(1'b1, 1'b1, 1'b1, 1'b1, 16'h1234);
        grp[1] = make_slot(1'b1, 1'b1, 1'b0, 1'b0, '0);
        send_group(grp);
        send_group(plain_group('1));
        resolve_branch(br_idx, 1'b1, 1'b0, '0);
        drain(200);
        end_test("correct branch");

        send_group(plain_group('1));
        br_idx = ref_tail;
        grp[0] = make_slot(1'b1, 1'b1, 1'b1, 1'b0, 16'hbeef);
        grp[1] = make_slot(1'b1, 1'b1, 1'b0, 1'b0, '0);
        send_group(grp);
        send_group(plain_group('1));
        resolve_branch(br_idx, 1'b1, 1'b1, 16'hbeef);
        // refill behind the branch
        send_group(plain_group('1));
        drain(200);
        end_test("misprediction");

        set_completions(1'b0);
        grp[0] = make_slot(1'b0, 1'b1, 1'b0, 1'b0, '0);
        grp[1] = make_slot(1'b0, 1'b1, 1'b0, 1'b0, '0);
        send_group(grp);
        send_group(grp);
        drain(50);
        end_test("nop slots");

        $display("summary: %0d tests run, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
